// File: Makefile
TOP := PipeCtrlTb

all: run

build:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f project.f -o sim

run: build
	./obj_dir/sim +verilator+error+limit+1000000 > sim.log 2>&1 || \
		echo "Testbench failed" >> sim.log
	cat sim.log
	@if grep -q "Testbench failed" sim.log; then echo "Simulation FAILED"; exit 1; fi

lint:
	verilator --lint-only -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: dv/PipeCtrlTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline control testbench
// Random fetch stream, stalls and exceptions checked against a
// cycle model of the controller and the stage chain
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module PipeCtrlTb;
    import PipeCtrlPkg::*;

    localparam int MulDivCycles = 4;
    localparam int NumCycles    = 2000;
    localparam int CycleLimit   = NumCycles + 200;

    logic       clk = 1'b0;
    logic       reset;
    instrInfo_t fetchInstr;
    memStall_t  memStall;
    logic       flushException;
    logic       fetchTake;
    logic       retireValid;
    instrInfo_t retire;
    pipeCtrl_t  ctrl;
    logic       iReqValid;
    logic       dReqValid;
    logic       iCacheStall;
    logic       dCacheStall;

    // Model state and expected outputs
    instrInfo_t      mdl [NumStages];
    int              mdlCount;
    pipeCtrl_t       expCtrl;
    logic            expIReq;
    logic            expDReq;
    logic            expIStall;
    logic            expDStall;
    logic            expTake;
    logic            expRetire;
    logic [TagW-1:0] nextTag;
    logic [TagW-1:0] lastTag;
    int              retiredCount = 0;
    int              seed = 32'hc80972ae;
    int              mismatchCount = 0;
    int              failCount = 0;
    int              cycleCount = 0;

    PipeCtrlTop #(
        .MulDivCycles (MulDivCycles)
    ) u_PipeCtrlTop (
        .clk            (clk),
        .reset          (reset),
        .fetchInstr     (fetchInstr),
        .memStall       (memStall),
        .flushException (flushException),
        .fetchTake      (fetchTake),
        .retireValid    (retireValid),
        .retire         (retire),
        .ctrl           (ctrl),
        .iReqValid      (iReqValid),
        .dReqValid      (dReqValid),
        .iCacheStall    (iCacheStall),
        .dCacheStall    (dCacheStall)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", CycleLimit);
            $display("Checks done: %0d mismatches, %0d other failures",
                     mismatchCount, failCount + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    // Producer at pipeline position pos (0 = EXE) not yet forwardable to ID
    function automatic logic notReady(input instrInfo_t prod, input int pos);
        logic match;
        match = (prod.destReg == mdl[StId].src1Reg) || (prod.destReg == mdl[StId].src2Reg);
        return prod.valid && mdl[StId].valid && (prod.destReg != '0) && match
            && (int'(prod.ready) > pos);
    endfunction

    function automatic logic pipeEmpty();
        logic empty;
        empty = (mdlCount == 0);
        for (int k = 0; k < NumStages; k++) begin
            empty = empty && !mdl[k].valid;
        end
        return empty;
    endfunction

    task automatic newInstr(input logic quiet);
        logic [31:0] r;
        r = $random(seed);
        fetchInstr             = '0;
        fetchInstr.valid       = !quiet;
        fetchInstr.tag         = nextTag;
        fetchInstr.destReg     = {3'b000, r[1:0]};   // r0..r3 only
        fetchInstr.src1Reg     = {3'b000, r[3:2]};
        fetchInstr.src2Reg     = {3'b000, r[5:4]};
        fetchInstr.ready       = readyStage_e'(r[7:6]);
        fetchInstr.isMulDiv    = (r[11:8] == 4'd0);
        fetchInstr.isBranch    = (r[14:12] == 3'd0);
        fetchInstr.mispredict  = r[15];
        fetchInstr.likelyTaken = r[16];
        nextTag = nextTag + TagW'(1);
    endtask

    task automatic driveStalls(input logic quiet);
        logic [31:0] r;
        r = $random(seed);
        memStall.iTlbStall  = !quiet && (r[5:0] == 6'd0);
        memStall.dTlbStall  = !quiet && (r[11:6] == 6'd0);
        memStall.iCacheBusy = !quiet && (r[17:12] == 6'd0);
        memStall.dCacheBusy = !quiet && (r[23:18] == 6'd0);
        flushException      = !quiet && (r[29:24] == 6'd0);
    endtask

    task automatic predict();
        logic hzExe;
        logic hzMem;
        logic hzMem2;
        logic busy;
        logic misp;
        logic likely;
        hzExe  = notReady(mdl[StExe], 0);
        hzMem  = notReady(mdl[StMem], 1);
        hzMem2 = notReady(mdl[StMem2], 2);
        busy   = (mdlCount != 0);
        misp   = mdl[StExe].valid && mdl[StExe].isBranch && mdl[StExe].mispredict;
        likely = mdl[StExe].valid && mdl[StExe].isBranch && mdl[StExe].likelyTaken;
        expCtrl   = '0;
        expIStall = 1'b0;
        expDStall = 1'b0;
        if (memStall != '0 || busy) begin      // Cache, TLB or mul/div freeze
            expCtrl.memDisWr = 1'b1;
            expCtrl.wbDisWr  = 1'b1;
            expIStall        = 1'b1;
            expDStall        = 1'b1;
        end else if (flushException) begin
            expCtrl.wr       = 7'b1100001;
            expCtrl.flush    = 7'b0011110;
            expCtrl.memDisWr = 1'b1;
        end else if (hzMem2) begin
            expCtrl.wr       = 7'b1100000;
            expCtrl.flush    = 7'b0100000;
            expCtrl.memDisWr = 1'b1;
            expIStall        = 1'b1;
        end else if (hzMem) begin
            expCtrl.wr    = 7'b1110000;
            expCtrl.flush = 7'b0010000;
            expIStall     = 1'b1;
        end else if (hzExe) begin
            expCtrl.wr      = 7'b1111000;
            expCtrl.flush   = 7'b0001000;
            expCtrl.idDisWr = 1'b1;
            expIStall       = 1'b1;
        end else if (misp) begin
            expCtrl.wr    = 7'b1111001;        // PREIF refetches
            expCtrl.flush = {3'b000, likely, 3'b110};
        end else begin
            expCtrl.wr    = '1;
            expCtrl.flush = {3'b000, likely, 3'b000};
        end
        expCtrl.exeDisWr = flushException || hzMem || busy;
        expIReq   = !(flushException || hzExe || hzMem || hzMem2 || misp);
        expDReq   = !flushException;
        expTake   = expCtrl.wr[StPreIf] && expIReq;
        expRetire = mdl[StWb].valid && expCtrl.wr[StWb] && !expCtrl.wbDisWr;
    endtask

    task automatic checkOutputs();
        logic [TagW-1:0] gap;
        assert (ctrl == expCtrl) else begin
            mismatchCount++;
            $display("mismatch at %0t: ctrl %h, expected %h", $time, ctrl, expCtrl);
        end
        assert ({iReqValid, dReqValid, iCacheStall, dCacheStall}
                == {expIReq, expDReq, expIStall, expDStall}) else begin
            mismatchCount++;
            $display("mismatch at %0t: cache levels %b%b%b%b, expected %b%b%b%b", $time,
                     iReqValid, dReqValid, iCacheStall, dCacheStall,
                     expIReq, expDReq, expIStall, expDStall);
        end
        assert (fetchTake == expTake && retireValid == expRetire) else begin
            mismatchCount++;
            $display("mismatch at %0t: fetchTake %b retireValid %b, expected %b %b",
                     $time, fetchTake, retireValid, expTake, expRetire);
        end
        assert (retire == mdl[StWb]) else begin
            mismatchCount++;
            $display("mismatch at %0t: retire %h, expected %h", $time, retire, mdl[StWb]);
        end
        if (retireValid) begin
            gap = retire.tag - lastTag;         // Skips allowed, wraps at 256
            assert (retiredCount == 0 || (gap != '0 && !gap[TagW-1])) else begin
                failCount++;
                $display("retired tag %0d out of order after tag %0d", retire.tag, lastTag);
            end
            lastTag = retire.tag;
            retiredCount++;
        end
    endtask

    task automatic advance();
        instrInfo_t prev [NumStages];
        prev = mdl;
        if (prev[StId].valid && prev[StId].isMulDiv
                && expCtrl.wr[StExe] && !expCtrl.flush[StExe]) begin
            mdlCount = MulDivCycles;
        end else if (mdlCount != 0) begin
            mdlCount--;
        end
        for (int k = 0; k < NumStages; k++) begin
            if (expCtrl.flush[k]) begin
                mdl[k] = '0;
            end else if (expCtrl.wr[k]) begin
                mdl[k] = (k == 0) ? (expTake ? fetchInstr : '0) : prev[k-1];
            end
        end
    endtask

    // Starts and ends on a falling edge
    task automatic stepCycle(input logic quiet);
        driveStalls(quiet);
        predict();
        @(posedge clk);
        checkOutputs();
        advance();
        @(negedge clk);
        if (expTake) begin
            newInstr(quiet);
        end
    endtask

    initial begin
        reset          = 1'b1;
        memStall       = '0;
        flushException = 1'b0;
        fetchInstr     = '0;
        nextTag        = '0;
        lastTag        = '0;
        mdlCount       = 0;
        for (int k = 0; k < NumStages; k++) begin
            mdl[k] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        newInstr(1'b0);
        for (int n = 0; n < NumCycles; n++) begin
            stepCycle(1'b0);
        end
        fetchInstr.valid = 1'b0;                // Drain with no new work
        while (!pipeEmpty()) begin
            stepCycle(1'b1);
        end
        assert (retiredCount > 0) else begin
            failCount++;
            $display("no instruction retired during the run");
        end
        $display("Checks done: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: project.f
verilog/PipeCtrlPkg.sv
verilog/StageChain.sv
verilog/HazardDetect.sv
verilog/MulDivBusy.sv
verilog/Control.sv
verilog/PipeCtrlTop.sv
dv/PipeCtrlTb.sv

// File: verilog/Control.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline controller
// Fixed-priority choice of stall/flush case, giving per-stage
// write enables, flushes, disable-writes and cache levels
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module Control (
    input  PipeCtrlPkg::memStall_t   memStall,
    input  PipeCtrlPkg::hazard_t     hazard,
    input  logic                     mulDivBusy,
    input  logic                     flushException,
    input  PipeCtrlPkg::pipeStages_t stages,
    output PipeCtrlPkg::pipeCtrl_t   ctrl,
    output logic                     iReqValid,
    output logic                     dReqValid,
    output logic                     iCacheStall,
    output logic                     dCacheStall
);
    import PipeCtrlPkg::*;

    ctrlCase_e ctrlCase;
    logic      mispredict;
    logic      likelyFlush;
    logic      anyHazard;

    assign mispredict  = stages.exe.valid && stages.exe.isBranch && stages.exe.mispredict;
    assign likelyFlush = stages.exe.valid && stages.exe.isBranch && stages.exe.likelyTaken;
    assign anyHazard   = hazard.exeHazard || hazard.mem1Hazard || hazard.mem2Hazard;

    always_comb begin
        if (memStall.dTlbStall || memStall.dCacheBusy) begin
            ctrlCase = caseDStall;
        end else if (memStall.iTlbStall || memStall.iCacheBusy) begin
            ctrlCase = caseIStall;
        end else if (mulDivBusy) begin
            ctrlCase = caseMulDiv;
        end else if (flushException) begin
            ctrlCase = caseException;
        end else if (hazard.mem2Hazard) begin
            ctrlCase = caseMem2Hazard;
        end else if (hazard.mem1Hazard) begin
            ctrlCase = caseMem1Hazard;
        end else if (hazard.exeHazard) begin
            ctrlCase = caseExeHazard;
        end else if (mispredict) begin
            ctrlCase = caseMispredict;
        end else begin
            ctrlCase = caseRun;
        end
    end

    always_comb begin
        ctrl        = '0;
        iCacheStall = 1'b0;
        dCacheStall = 1'b0;
        unique case (ctrlCase)
            caseDStall, caseIStall, caseMulDiv: begin
                // Whole pipe frozen
                ctrl.memDisWr = 1'b1;
                ctrl.wbDisWr  = 1'b1;
                iCacheStall   = 1'b1;
                dCacheStall   = 1'b1;
            end
            caseException: begin
                ctrl.wr       = 7'b1100001;
                ctrl.flush    = 7'b0011110;   // IF through MEM
                ctrl.memDisWr = 1'b1;
            end
            caseMem2Hazard: begin
                ctrl.wr       = 7'b1100000;
                ctrl.flush    = 7'b0100000;   // Bubble into MEM2
                ctrl.memDisWr = 1'b1;
                iCacheStall   = 1'b1;
            end
            caseMem1Hazard: begin
                ctrl.wr     = 7'b1110000;
                ctrl.flush  = 7'b0010000;     // Bubble into MEM
                iCacheStall = 1'b1;
            end
            caseExeHazard: begin
                ctrl.wr      = 7'b1111000;
                ctrl.flush   = 7'b0001000;    // Bubble into EXE
                ctrl.idDisWr = 1'b1;
                iCacheStall  = 1'b1;
            end
            caseMispredict: begin
                ctrl.wr           = 7'b1111001;
                ctrl.flush        = 7'b0000110;
                ctrl.flush[StExe] = likelyFlush;  // Annul delay slot
            end
            default: begin
                ctrl.wr           = '1;
                ctrl.flush[StExe] = likelyFlush;
            end
        endcase
        // HILO write block, independent of the case row
        ctrl.exeDisWr = flushException || hazard.mem1Hazard || mulDivBusy;
    end

    assign iReqValid = !(flushException || anyHazard || mispredict);
    assign dReqValid = !flushException;

    // Hazard rows bubble with iCacheStall alone, a frozen pipe never flushes
    always_comb begin
        if (dCacheStall) begin
            noFlushInStall : assert (ctrl.flush == '0)
                else $error("flush raised while the pipe is frozen");
        end
    end

endmodule

// File: verilog/HazardDetect.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hazard detector
// Read-after-write check of the ID sources against EXE, MEM
// and MEM2 destinations whose result is not yet ready
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module HazardDetect (
    input  PipeCtrlPkg::pipeStages_t stages,
    output PipeCtrlPkg::hazard_t     hazard
);
    import PipeCtrlPkg::*;

    // Producer sitting in stage atStage cannot forward to consumer yet
    function automatic logic rawHit(
        input instrInfo_t  prod,
        input instrInfo_t  cons,
        input readyStage_e atStage
    );
        logic srcMatch;
        srcMatch = (prod.destReg == cons.src1Reg) || (prod.destReg == cons.src2Reg);
        rawHit   = prod.valid && cons.valid
                && (prod.destReg != '0)     // r0 never conflicts
                && srcMatch
                && (prod.ready > atStage);
    endfunction

    always_comb begin
        hazard.exeHazard  = rawHit(stages.exe,  stages.id, rdyExe);
        hazard.mem1Hazard = rawHit(stages.mem,  stages.id, rdyMem);
        hazard.mem2Hazard = rawHit(stages.mem2, stages.id, rdyMem2);
    end

endmodule

// File: verilog/MulDivBusy.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply/divide occupancy counter
// Keeps EXE busy for MulDivCycles cycles after a mul/div enters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module MulDivBusy #(
    parameter int MulDivCycles = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  PipeCtrlPkg::pipeStages_t stages,
    input  PipeCtrlPkg::pipeCtrl_t   ctrl,
    output logic                     mulDivBusy
);
    import PipeCtrlPkg::*;

    localparam int CntW = $clog2(MulDivCycles + 1);

    logic [CntW-1:0] count;
    logic            issue;

    // ID mul/div actually lands in EXE on this edge
    assign issue = stages.id.valid && stages.id.isMulDiv
                && ctrl.wr[StExe] && !ctrl.flush[StExe];

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (issue) begin
            count <= CntW'(MulDivCycles);
        end else if (count != '0) begin
            count <= count - CntW'(1);
        end
    end

    assign mulDivBusy = (count != '0);

    busyOwner : assert property (@(posedge clk) disable iff (reset)
        mulDivBusy |-> stages.exe.valid && stages.exe.isMulDiv)
        else $error("mul/div busy without a mul/div in EXE");

endmodule

// File: verilog/PipeCtrlPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline control package
// Shared widths, stage indices, descriptors and control structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package PipeCtrlPkg;

    localparam int TagW      = 8;
    localparam int RegAddrW  = 5;
    localparam int NumStages = 7;

    // Bit positions in the wr and flush vectors
    localparam int StPreIf = 0;
    localparam int StIf    = 1;
    localparam int StId    = 2;
    localparam int StExe   = 3;
    localparam int StMem   = 4;
    localparam int StMem2  = 5;
    localparam int StWb    = 6;

    // Stage at whose end a result becomes forwardable
    typedef enum logic [1:0] {rdyExe, rdyMem, rdyMem2, rdyWb} readyStage_e;

    typedef struct packed {
        logic                valid;
        logic [TagW-1:0]     tag;
        logic [RegAddrW-1:0] destReg;
        logic [RegAddrW-1:0] src1Reg;
        logic [RegAddrW-1:0] src2Reg;
        readyStage_e         ready;
        logic                isMulDiv;
        logic                isBranch;
        logic                mispredict;
        logic                likelyTaken;
    } instrInfo_t;

    typedef struct packed {
        instrInfo_t preIf;
        instrInfo_t fetch;    // IF stage
        instrInfo_t id;
        instrInfo_t exe;
        instrInfo_t mem;
        instrInfo_t mem2;
        instrInfo_t wb;
    } pipeStages_t;

    typedef struct packed {
        logic iTlbStall;
        logic dTlbStall;
        logic iCacheBusy;
        logic dCacheBusy;
    } memStall_t;

    typedef struct packed {
        logic exeHazard;
        logic mem1Hazard;
        logic mem2Hazard;
    } hazard_t;

    typedef struct packed {
        logic [NumStages-1:0] wr;      // Bit 0 is PREIF
        logic [NumStages-1:0] flush;
        logic                 idDisWr;
        logic                 exeDisWr;
        logic                 memDisWr;
        logic                 wbDisWr;
    } pipeCtrl_t;

    // Listed from highest to lowest priority
    typedef enum logic [3:0] {
        caseDStall,
        caseIStall,
        caseMulDiv,
        caseException,
        caseMem2Hazard,
        caseMem1Hazard,
        caseExeHazard,
        caseMispredict,
        caseRun
    } ctrlCase_e;

endpackage

// File: verilog/PipeCtrlTop.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline control top level
// Stage chain, hazard detector, mul/div counter and controller
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module PipeCtrlTop #(
    parameter int MulDivCycles = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  PipeCtrlPkg::instrInfo_t fetchInstr,
    input  PipeCtrlPkg::memStall_t  memStall,
    input  logic                    flushException,
    output logic                    fetchTake,
    output logic                    retireValid,
    output PipeCtrlPkg::instrInfo_t retire,
    output PipeCtrlPkg::pipeCtrl_t  ctrl,
    output logic                    iReqValid,
    output logic                    dReqValid,
    output logic                    iCacheStall,
    output logic                    dCacheStall
);
    import PipeCtrlPkg::*;

    pipeStages_t stages;
    hazard_t     hazard;
    logic        mulDivBusy;

    StageChain u_StageChain (
        .clk         (clk),
        .reset       (reset),
        .fetchInstr  (fetchInstr),
        .ctrl        (ctrl),
        .iReqValid   (iReqValid),
        .stages      (stages),
        .fetchTake   (fetchTake),
        .retireValid (retireValid),
        .retire      (retire)
    );

    HazardDetect u_HazardDetect (
        .stages (stages),
        .hazard (hazard)
    );

    MulDivBusy #(
        .MulDivCycles (MulDivCycles)
    ) u_MulDivBusy (
        .clk        (clk),
        .reset      (reset),
        .stages     (stages),
        .ctrl       (ctrl),
        .mulDivBusy (mulDivBusy)
    );

    Control u_Control (
        .memStall       (memStall),
        .hazard         (hazard),
        .mulDivBusy     (mulDivBusy),
        .flushException (flushException),
        .stages         (stages),
        .ctrl           (ctrl),
        .iReqValid      (iReqValid),
        .dReqValid      (dReqValid),
        .iCacheStall    (iCacheStall),
        .dCacheStall    (dCacheStall)
    );

endmodule

// File: verilog/StageChain.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage chain
// Seven descriptor registers from PREIF to WB, written, held
// or bubbled per stage by the controller
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module StageChain (
    input  logic                     clk,
    input  logic                     reset,
    input  PipeCtrlPkg::instrInfo_t  fetchInstr,
    input  PipeCtrlPkg::pipeCtrl_t   ctrl,
    input  logic                     iReqValid,
    output PipeCtrlPkg::pipeStages_t stages,
    output logic                     fetchTake,
    output logic                     retireValid,
    output PipeCtrlPkg::instrInfo_t  retire
);
    import PipeCtrlPkg::*;

    instrInfo_t stageQ  [NumStages];
    instrInfo_t stageIn [NumStages];

    // Fetch only accepted when PREIF moves and the I-side may request
    assign fetchTake = ctrl.wr[StPreIf] && iReqValid;

    always_comb begin
        stageIn[StPreIf] = fetchTake ? fetchInstr : '0;
        for (int k = 1; k < NumStages; k++) begin
            stageIn[k] = stageQ[k-1];
        end
    end

    // Flush wins over write
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < NumStages; k++) begin
                stageQ[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NumStages; k++) begin
                if (ctrl.flush[k]) begin
                    stageQ[k] <= '0;         // Bubble
                end else if (ctrl.wr[k]) begin
                    stageQ[k] <= stageIn[k];
                end
            end
        end
    end

    always_comb begin
        stages.preIf = stageQ[StPreIf];
        stages.fetch = stageQ[StIf];
        stages.id    = stageQ[StId];
        stages.exe   = stageQ[StExe];
        stages.mem   = stageQ[StMem];
        stages.mem2  = stageQ[StMem2];
        stages.wb    = stageQ[StWb];
    end

    assign retire      = stageQ[StWb];
    assign retireValid = stageQ[StWb].valid && ctrl.wr[StWb] && !ctrl.wbDisWr;

    // WB must not move on the edge after a disable-write cycle
    wbHoldCheck : assert property (@(posedge clk) disable iff (reset)
        ctrl.wbDisWr && !ctrl.flush[StWb] |=> $stable(stageQ[StWb]))
        else $error("WB stage loaded while wbDisWr was high");

endmodule
